// ==== src/gem_rx_config.svh ====
`ifndef GEM_RX_CONFIG_SVH
`define GEM_RX_CONFIG_SVH

// ------------------------------
// Line and frame geometry
// ------------------------------
`define GEM_WORD_W       16   // One decoded 8b10b word
`define GEM_FRAME_WORDS  4    // Words per BX
`define GEM_FRAME_W      56   // Words 3..1 plus data byte of word 0
`define GEM_KCHAR_W      8    // K-character in low byte of word 0

// ------------------------------
// Link monitor limits
// ------------------------------
`define GEM_GOOD_BX      15   // Clean BX before link is declared good
`define GEM_ERR_SAT_NIB  4'hE // Loss count stops when top nibble hits this

// Received data when no frame phase is active
`define GEM_IDLE_FILL    {`GEM_FRAME_W{1'b1}}

`endif

// ==== src/gem_link_pkg.sv ====
`default_nettype none

`include "gem_rx_config.svh"

package gem_link_pkg;

    // ------------------------------
    // One word out of the transceiver
    // ------------------------------
    typedef struct packed {
        logic [`GEM_WORD_W-1:0] data;       // Decoded data, high byte first
        logic [1:0]             isk;        // K flag per byte
        logic [1:0]             notintable; // Symbol not in 8b10b table
        logic                   lossofsync; // Receiver lost comma sync
    } rx_word_t;

    // GEM K-characters seen in the low byte of word 0
    // Normal EOF markers cycle bc, f7, fb, fd
    // Overflow marker fc fires the latency trigger
    typedef enum logic [`GEM_KCHAR_W-1:0] {
        k_bc = 8'hBC,
        k_f7 = 8'hF7,
        k_fb = 8'hFB,
        k_fd = 8'hFD,
        k_fc = 8'hFC
    } kchar_e;

endpackage

`default_nettype wire

// ==== src/gem_frame_pkg.sv ====
`default_nettype none

`include "gem_rx_config.svh"

package gem_frame_pkg;

    // Active BX phase, w0 wins over w1 over w2 over w3
    typedef enum logic [2:0] {
        ph_idle,
        ph_w0,
        ph_w1,
        ph_w2,
        ph_w3
    } frame_phase_e;

    // Word strobes, bit n is cew<n>
    typedef struct packed {
        logic cew3; // Last data word on the line
        logic cew2;
        logic cew1; // First data word after the comma
        logic cew0; // Comma word on the line
    } cew_t;

    // ------------------------------
    // Assembled frame
    // ------------------------------
    typedef struct packed {
        logic [`GEM_FRAME_W-1:0]     rcv_data;     // w3, w2, w1, w0 high byte
        logic [`GEM_KCHAR_W-1:0]     k_char;       // EOF marker of the frame
        logic [`GEM_FRAME_WORDS-1:0] nonzero_word; // Per-word nonzero flags
        logic                        ltncy_trig;   // Overflow K seen
    } frame_out_t;

    // Link health summary
    typedef struct packed {
        logic       link_good;    // 1 + 15 clean BX seen
        logic       link_had_err; // Sticky loss or never up
        logic       link_bad;     // Loss count MSB
        logic [7:0] errcount;     // Saturating loss count
    } link_status_t;

endpackage

`default_nettype wire

// ==== src/gem_frame_phase.sv ====
`timescale 1ns/1ns
`default_nettype none

module gem_frame_phase (
    input  wire                          GEM_RX_CLK160,
    input  wire                          gem_rx_resetdone,
    input  wire gem_link_pkg::rx_word_t  rx,
    output gem_frame_pkg::cew_t          cew,
    output gem_frame_pkg::frame_phase_e  phase
);
    import gem_frame_pkg::*;

    // Comma sits in low byte only
    wire comma = (rx.isk == 2'b01);

    // ------------------------------
    // BX phase chain
    // ------------------------------
    // Comma at edge n gives cew1 after n, then cew2, cew3, cew0
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            cew.cew0 <= 1'b0;
            cew.cew1 <= 1'b0;
            cew.cew2 <= 1'b0;
            cew.cew3 <= 1'b0;
        end else begin
            cew.cew1 <= comma;    // Next word is word 1
            cew.cew2 <= cew.cew1;
            cew.cew3 <= cew.cew2;
            cew.cew0 <= cew.cew3; // Wraps to the next comma slot
        end
    end

    // Priority encode for the capture case downstream
    // Overlap only happens with commas closer than four words
    always_comb begin
        if (cew.cew0) begin
            phase = ph_w0;
        end else if (cew.cew1) begin
            phase = ph_w1;
        end else if (cew.cew2) begin
            phase = ph_w2;
        end else if (cew.cew3) begin
            phase = ph_w3;
        end else begin
            phase = ph_idle; // Stream not framed
        end
    end

endmodule

`default_nettype wire

// ==== src/gem_frame_assembler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gem_rx_config.svh"

module gem_frame_assembler (
    input  wire                               GEM_RX_CLK160,
    input  wire                               gem_rx_resetdone,
    input  wire                               frame_clr,
    input  wire gem_link_pkg::rx_word_t       rx,
    input  wire gem_frame_pkg::cew_t          cew,
    input  wire gem_frame_pkg::frame_phase_e  phase,
    output gem_frame_pkg::frame_out_t         frame,
    output logic [`GEM_FRAME_W-1:0]           prompt_data,
    output logic [`GEM_FRAME_WORDS-1:0]       mon_in
);
    import gem_link_pkg::*;
    import gem_frame_pkg::*;

    // ------------------------------
    // Word holding registers
    // ------------------------------
    logic [`GEM_WORD_W-1:0] w0_reg;     // Comma word, data byte on top
    logic [`GEM_WORD_W-1:0] w1_reg;
    logic [`GEM_WORD_W-1:0] w2_reg;
    logic                   lt_trg_reg; // Overflow K waiting for word 3

    logic clean_line; // In sync and every symbol decoded
    logic is_comma;
    logic is_data;    // Clean word with no K flags
    logic eof_ok;     // Bits 7, 5, 4 set on every GEM EOF marker
    logic lt_trg;

    assign clean_line = !rx.lossofsync && (rx.notintable == 2'b00);
    assign is_comma   = (rx.isk == 2'b01);
    assign is_data    = clean_line && (rx.isk == 2'b00);
    assign eof_ok     = ({rx.data[7], rx.data[5:4]} == 3'b111);
    assign lt_trg     = is_comma && (rx.data[`GEM_KCHAR_W-1:0] == k_fc);

    // Frame as it stands on the line right now
    assign prompt_data = {rx.data, w2_reg, w1_reg, w0_reg[`GEM_WORD_W-1:`GEM_KCHAR_W]};

    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            w0_reg             <= '0;
            w1_reg             <= '0;
            w2_reg             <= '0;
            lt_trg_reg         <= 1'b0;
            frame.rcv_data     <= `GEM_IDLE_FILL;
            frame.k_char       <= '0;
            frame.nonzero_word <= '0;
            frame.ltncy_trig   <= 1'b0;
            mon_in             <= '0;
        end else if (frame_clr) begin
            // Resync or lost alignment, words are left as they are
            frame.rcv_data     <= `GEM_IDLE_FILL;
            frame.k_char       <= '0;
            frame.nonzero_word <= '0;
            frame.ltncy_trig   <= 1'b0;
            mon_in             <= '0;
        end else begin
            case (phase)
                ph_w0: begin
                    w0_reg                <= rx.data;
                    lt_trg_reg            <= lt_trg;
                    // Only the data byte counts, low byte is the K-char
                    frame.nonzero_word[0] <= |rx.data[`GEM_WORD_W-1:`GEM_KCHAR_W];
                    mon_in[0]             <= clean_line && is_comma && eof_ok;
                end
                ph_w1: begin
                    w1_reg                <= rx.data; // First data after EOF
                    frame.nonzero_word[1] <= |rx.data;
                    mon_in[1]             <= is_data && !cew.cew2 && !cew.cew3;
                end
                ph_w2: begin
                    w2_reg                <= rx.data;
                    frame.nonzero_word[2] <= |rx.data;
                    mon_in[2]             <= is_data && !cew.cew3;
                end
                ph_w3: begin
                    // Publish the whole BX
                    frame.rcv_data        <= {rx.data, w2_reg, w1_reg,
                                              w0_reg[`GEM_WORD_W-1:`GEM_KCHAR_W]};
                    frame.k_char          <= w0_reg[`GEM_KCHAR_W-1:0];
                    frame.ltncy_trig      <= lt_trg_reg;
                    frame.nonzero_word[3] <= |rx.data;
                    mon_in[3]             <= is_data;
                end
                default: begin
                    // No phase, link is down or not yet framed
                    frame.rcv_data     <= `GEM_IDLE_FILL;
                    frame.ltncy_trig   <= 1'b0;
                    frame.nonzero_word <= '0;
                    mon_in             <= '0; // Forces mon_rst next cycle
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/gem_link_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gem_rx_config.svh"

module gem_link_monitor (
    input  wire                          GEM_RX_CLK160,
    input  wire                          gem_rx_resetdone,
    input  wire                          frame_clr,
    input  wire gem_frame_pkg::cew_t     cew,
    input  wire [`GEM_FRAME_WORDS-1:0]   mon_in,
    output gem_frame_pkg::link_status_t  status
);
    localparam int               CNT_W   = $clog2(`GEM_GOOD_BX + 1);
    localparam logic [CNT_W-1:0] GOOD_BX = CNT_W'(`GEM_GOOD_BX);

    logic             mon_rst;   // Last BX was not fully clean
    logic [CNT_W-1:0] mon_count; // Clean BX since last problem
    logic             link_good;
    logic             link_err;  // Sticky, link dropped at least once
    logic [7:0]       err_count;

    // Was up and just saw a bad BX
    wire link_went_down = link_good && mon_rst;

    // ------------------------------
    // Health tracking
    // ------------------------------
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            mon_rst   <= 1'b1;
            mon_count <= '0;
            link_good <= 1'b0;
            link_err  <= 1'b0;
            err_count <= '0;
        end else if (frame_clr) begin
            mon_rst   <= 1'b1; // Link counts as never up
            mon_count <= '0;
            link_good <= 1'b0;
            link_err  <= 1'b0;
            err_count <= '0;
        end else begin
            mon_rst <= (mon_in != '1);

            // Good-BX counter, holds once link is good
            if (mon_rst) begin
                mon_count <= '0;
            end else if (!link_good && cew.cew3) begin
                mon_count <= mon_count + 1'b1;
            end

            link_good <= !mon_rst && (mon_count == GOOD_BX);

            if (link_went_down) begin
                link_err <= 1'b1;
            end
            // Count losses, stop short of wrapping
            if (link_went_down && (err_count[7:4] != `GEM_ERR_SAT_NIB)) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    assign status.link_good    = link_good;
    assign status.link_had_err = link_err || mon_rst; // Also set before first link up
    assign status.link_bad     = err_count[7];
    assign status.errcount     = err_count;

endmodule

`default_nettype wire

// ==== src/gem_rx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gem_rx_config.svh"

module gem_rx_top (
    input  wire                          GEM_RX_CLK160,
    input  wire                          gem_rx_resetdone,
    input  wire gem_link_pkg::rx_word_t  rx,
    input  wire                          rx_sync_done,
    input  wire                          ttc_resync,
    output gem_frame_pkg::frame_out_t    frame,
    output logic [`GEM_FRAME_W-1:0]      prompt_data,
    output gem_frame_pkg::cew_t          cew,
    output gem_frame_pkg::link_status_t  status
);
    import gem_frame_pkg::*;

    frame_phase_e                phase;
    logic [`GEM_FRAME_WORDS-1:0] mon_in; // Per-word health of last BX

    // Common sync clear for assembler and monitor
    wire frame_clr = !rx_sync_done || ttc_resync;

    // ------------------------------
    // Phase, assembly, monitor
    // ------------------------------
    gem_frame_phase phase_i (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .rx               (rx),
        .cew              (cew),
        .phase            (phase)
    );

    gem_frame_assembler assembler_i (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .frame_clr        (frame_clr),
        .rx               (rx),
        .cew              (cew),
        .phase            (phase),
        .frame            (frame),
        .prompt_data      (prompt_data),
        .mon_in           (mon_in)
    );

    gem_link_monitor monitor_i (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .frame_clr        (frame_clr),
        .cew              (cew),    // Counts BX on cew3
        .mon_in           (mon_in),
        .status           (status)
    );

endmodule

`default_nettype wire

// ==== dv/gem_rx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gem_rx_config.svh"

module gem_rx_tb;
    import gem_link_pkg::*;
    import gem_frame_pkg::*;

    localparam int PERIOD     = 8;
    localparam int N_UP       = 40;  // Clean frames for first link up
    localparam int N_MIX      = 80;  // Random frames with some faulted
    localparam int N_CLR      = 24;  // Frames around the clear tests
    localparam int SAT_LOOPS  = 230; // Link losses needed to saturate
    localparam int SAT_RUN    = 20;  // Clean frames before each loss
    localparam int N_FRAMES   = N_UP + N_MIX + N_CLR + SAT_LOOPS * (SAT_RUN + 1);
    localparam int WATCHDOG_NS = (N_FRAMES * `GEM_FRAME_WORDS + 500) * PERIOD;

    logic                    GEM_RX_CLK160;
    logic                    gem_rx_resetdone;
    rx_word_t                rx;
    logic                    rx_sync_done;
    logic                    ttc_resync;
    frame_out_t              frame;
    logic [`GEM_FRAME_W-1:0] prompt_data;
    cew_t                    cew;
    link_status_t            status;

    logic [15:0] lfsr;          // Galois LFSR state
    logic        sync_lvl;      // Level driven on rx_sync_done
    int          mismatch_cnt;
    int          fail_cnt;

    // ------------------------------
    // Reference model state
    // ------------------------------
    cew_t                    m_cew;
    logic [`GEM_WORD_W-1:0]  m_w0;
    logic [`GEM_WORD_W-1:0]  m_w1;
    logic [`GEM_WORD_W-1:0]  m_w2;
    logic                    m_lt;      // Word 0 was an overflow K
    frame_out_t              m_frame;
    logic [3:0]              m_mon_in;
    logic                    m_mon_rst;
    int                      m_cnt;
    logic                    m_good;
    logic                    m_err;
    logic [7:0]              m_errcnt;

    gem_rx_top dut_i (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .rx               (rx),
        .rx_sync_done     (rx_sync_done),
        .ttc_resync       (ttc_resync),
        .frame            (frame),
        .prompt_data      (prompt_data),
        .cew              (cew),
        .status           (status)
    );

    initial begin
        GEM_RX_CLK160 = 1'b0;
        forever #(PERIOD / 2) GEM_RX_CLK160 = ~GEM_RX_CLK160;
    end

    // Reference model stepping on the rising edge
    always @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            m_cew <= '0;
            {m_w0, m_w1, m_w2, m_lt} <= '0;
            m_frame <= '{rcv_data: `GEM_IDLE_FILL, default: '0};
            m_mon_in <= '0;
            m_mon_rst <= 1'b1; // Link never up
            {m_cnt, m_good, m_err, m_errcnt} <= '0;
        end else begin
            // Comma shifts through w1, w2, w3 and wraps to w0
            m_cew <= {m_cew.cew2, m_cew.cew1, rx.isk == 2'b01, m_cew.cew3};
            if (!rx_sync_done || ttc_resync) begin
                m_frame <= '{rcv_data: `GEM_IDLE_FILL, default: '0};
                m_mon_in <= '0;
                m_mon_rst <= 1'b1;
                {m_cnt, m_good, m_err, m_errcnt} <= '0;
            end else begin
                if (m_cew.cew0) begin
                    m_w0 <= rx.data;
                    m_lt <= rx.isk == 2'b01 && rx.data[7:0] == k_fc;
                    m_frame.nonzero_word[0] <= rx.data[15:8] != 0;
                    m_mon_in[0] <= !rx.lossofsync && rx.notintable == 0 && rx.isk == 2'b01
                                   && rx.data[7] && rx.data[5] && rx.data[4];
                end else if (m_cew.cew1) begin
                    m_w1 <= rx.data;
                    m_frame.nonzero_word[1] <= rx.data != 0;
                    m_mon_in[1] <= !rx.lossofsync && rx.notintable == 0 && rx.isk == 0
                                   && !m_cew.cew2 && !m_cew.cew3;
                end else if (m_cew.cew2) begin
                    m_w2 <= rx.data;
                    m_frame.nonzero_word[2] <= rx.data != 0;
                    m_mon_in[2] <= !rx.lossofsync && rx.notintable == 0 && rx.isk == 0
                                   && !m_cew.cew3;
                end else if (m_cew.cew3) begin
                    m_frame.rcv_data <= {rx.data, m_w2, m_w1, m_w0[15:8]};
                    m_frame.k_char <= m_w0[7:0];
                    m_frame.ltncy_trig <= m_lt;
                    m_frame.nonzero_word[3] <= rx.data != 0;
                    m_mon_in[3] <= !rx.lossofsync && rx.notintable == 0 && rx.isk == 0;
                end else begin
                    m_frame.rcv_data <= `GEM_IDLE_FILL; // Unframed stream
                    m_frame.ltncy_trig <= 1'b0;
                    m_frame.nonzero_word <= '0;
                    m_mon_in <= '0;
                end
                m_mon_rst <= m_mon_in != 4'hF;
                if (m_mon_rst) begin
                    m_cnt <= 0;
                end else if (!m_good && m_cew.cew3) begin
                    m_cnt <= m_cnt + 1;
                end
                m_good <= !m_mon_rst && m_cnt == `GEM_GOOD_BX;
                if (m_good && m_mon_rst) begin // Link lost
                    m_err <= 1'b1;
                    if (m_errcnt[7:4] != `GEM_ERR_SAT_NIB) begin
                        m_errcnt <= m_errcnt + 1;
                    end
                end
            end
        end
    end

    // ------------------------------
    // Random source
    // ------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic kchar_e pick_kchar();
        case (rand_bits(3))
            0, 1:    return k_bc;
            2:       return k_f7;
            3:       return k_fb;
            4, 5:    return k_fd;
            default: return k_fc; // Overflow marker fires ltncy_trig
        endcase
    endfunction

    task automatic compare_outputs();
        link_status_t            exp_status;
        logic [`GEM_FRAME_W-1:0] exp_prompt;
        exp_status = {m_good, m_err || m_mon_rst, m_errcnt[7], m_errcnt};
        exp_prompt = {rx.data, m_w2, m_w1, m_w0[15:8]}; // Current word on top
        if (frame !== m_frame) begin
            mismatch_cnt++;
            $display("mismatch frame expected %h actual %h", m_frame, frame);
        end
        if (prompt_data !== exp_prompt) begin
            mismatch_cnt++;
            $display("mismatch prompt_data expected %h actual %h", exp_prompt, prompt_data);
        end
        if (cew !== m_cew) begin
            mismatch_cnt++;
            $display("mismatch cew expected %h actual %h", m_cew, cew);
        end
        if (status !== exp_status) begin
            mismatch_cnt++;
            $display("mismatch status expected %h actual %h", exp_status, status);
        end
    endtask

    // Check last cycle's results before driving the next word
    task automatic drive_word(input rx_word_t w, input logic resync);
        @(negedge GEM_RX_CLK160);
        compare_outputs();
        rx = w;
        rx_sync_done = sync_lvl;
        ttc_resync = resync;
    endtask

    task automatic send_idle(input int n);
        for (int i = 0; i < n; i++) drive_word('0, 1'b0);
    endtask

    // Fault 1 not-in-table, 2 loss of sync, 3 stray K, 4 no comma or no EOF marker
    task automatic send_frame(input int fault, input int resync_word);
        rx_word_t   w [4];
        logic [7:0] hi;
        int         pos;
        hi = 8'(rand_bits(8));
        if (rand_bits(2) == 0) hi = '0;
        w[0] = '0;
        w[0].data = {hi, 8'(pick_kchar())};
        w[0].isk = 2'b01;
        for (int i = 1; i < 4; i++) begin
            w[i] = '0;
            w[i].data = 16'(rand_bits(16));
            if (rand_bits(2) == 0) w[i].data = '0; // Zero word for nonzero flags
        end
        pos = int'(rand_bits(2));
        case (fault)
            1:       w[pos].notintable = 2'b01;
            2:       w[pos].lossofsync = 1'b1;
            // Stray comma on words 1 and 3 overlaps the strobes
            3:       w[pos].isk = (pos == 0) ? 2'b11 : (pos[0] ? 2'b01 : 2'b10);
            4: begin
                if (pos[0]) begin
                    w[0].isk = 2'b00;
                end else begin
                    w[0].data[7:0] = 8'h3C; // K28.1 lacks the EOF bits
                end
            end
            default: ;
        endcase
        for (int i = 0; i < 4; i++) drive_word(w[i], i == resync_word);
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Timeout after %0d ns, stimulus did not complete", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        lfsr = 16'd86;
        {mismatch_cnt, fail_cnt} = '0;
        gem_rx_resetdone = 1'b0;
        rx = '0;
        rx_sync_done = 1'b0;
        ttc_resync = 1'b0;
        sync_lvl = 1'b1;
        repeat (10) @(negedge GEM_RX_CLK160);
        gem_rx_resetdone = 1'b1;
        send_idle(4);

        for (int i = 0; i < N_UP; i++) send_frame(0, -1);
        if (!status.link_good || status.link_had_err) begin
            fail_cnt++;
            $display("Link did not come up cleanly after %0d clean frames", N_UP);
        end

        for (int i = 0; i < N_MIX; i++) begin
            send_frame((rand_bits(2) == 0) ? int'(rand_bits(2)) + 1 : 0, -1);
        end
        send_idle(12); // Comma stream stops
        if (frame.rcv_data !== `GEM_IDLE_FILL || frame.ltncy_trig || frame.nonzero_word != 0) begin
            fail_cnt++;
            $display("Frame outputs did not return to idle after commas stopped");
        end

        // Resync pulse mid-frame and sync lost for two frames
        for (int i = 0; i < 20; i++) send_frame(0, -1);
        send_frame(0, 2);
        sync_lvl = 1'b0;
        send_frame(0, -1);
        send_frame(0, -1);
        sync_lvl = 1'b1;
        send_frame(0, -1);

        for (int i = 0; i < SAT_LOOPS; i++) begin
            for (int j = 0; j < SAT_RUN; j++) send_frame(0, -1);
            send_frame(1, -1);
        end
        if (status.errcount !== {`GEM_ERR_SAT_NIB, 4'h0} || !status.link_bad) begin
            fail_cnt++;
            $display("Loss count did not stop at the saturation value, got %h", status.errcount);
        end
        send_idle(2);

        $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/gem_link_pkg.sv
src/gem_frame_pkg.sv
src/gem_frame_phase.sv
src/gem_frame_assembler.sv
src/gem_link_monitor.sv
src/gem_rx_top.sv
dv/gem_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the GEM receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module gem_rx_tb -o gem_rx_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/gem_rx_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "All checks passed"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation did not report a pass"
exit 1
